/* all.f */
logic/gfxPkg.sv
logic/spanWalker.sv
logic/gfxRegs.sv
logic/drawSequencer.sv
logic/frameBufferPort.sv
logic/paletteLoader.sv
logic/graphicsController.sv
sim/frameBufferModel.sv
sim/graphicsController_asserts.sv
sim/graphicsController_tb.sv

/* logic/drawSequencer.sv */
`timescale 1ns/100ps
module drawSequencer (
	input  logic                  Clk,
	input  logic                  i_rstN,
	input  logic                  i_cmdValid,
	input  gfxPkg::drawRegs_t     i_regs,
	input  logic                  i_pxReady,
	input  logic                  i_rdValid,
	input  logic                  i_palDone,
	output logic                  o_cmdReady,
	output logic                  o_engineBusy,
	output logic                  o_pxValid,
	output gfxPkg::pixelReq_t     o_px,
	output logic                  o_palValid,
	output gfxPkg::paletteWr_t    o_pal
);

	typedef enum logic [2:0] {
		Idle,
		Decode,     // one cycle to look at the command
		Pixel,      // single write
		Read,       // single read request
		ReadWait,   // wait for returned byte
		Line,       // stream of writes along one axis
		Palette     // wait for the loader
	} state_e;

	state_e                       state;
	state_e                       nxtState;
	gfxPkg::drawRegs_t            cmdRegs;    // snapshot taken at accept
	logic                         isVert;
	logic                         spanLoad;
	logic                         spanStep;
	logic [gfxPkg::CoordW-1:0]    spanPos;
	logic                         spanLast;

	assign isVert   = (cmdRegs.command == gfxPkg::VLine);
	assign spanLoad = (state == Decode);                   // harmless for other commands
	assign spanStep = (state == Line) && i_pxReady;        // advance on each accepted write

	spanWalker spanWalker_i (
		.Clk     (Clk),
		.i_rstN  (i_rstN),
		.i_load  (spanLoad),
		.i_start (isVert ? cmdRegs.y1 : cmdRegs.x1),
		.i_end   (isVert ? cmdRegs.y2 : cmdRegs.x2),
		.i_step  (spanStep),
		.o_pos   (spanPos),
		.o_last  (spanLast)
	);

	always_ff @(posedge Clk) begin
		if (i_cmdValid && o_cmdReady)
			cmdRegs <= i_regs;
	end

	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN)
			state <= Idle;
		else
			state <= nxtState;
	end

	////////////////////
	// next state
	////////////////////
	always_comb begin
		nxtState = state;
		case (state)
			Idle: if (i_cmdValid) nxtState = Decode;
			Decode: begin
				case (cmdRegs.command)
					gfxPkg::PutPixel:       nxtState = Pixel;
					gfxPkg::GetPixel:       nxtState = Read;
					gfxPkg::HLine,
					gfxPkg::VLine:          nxtState = Line;
					gfxPkg::ProgramPalette: nxtState = Palette;
					default:                nxtState = Idle;   // unknown code does nothing
				endcase
			end
			Pixel: if (i_pxReady) nxtState = Idle;
			Read: if (i_pxReady) nxtState = ReadWait;
			ReadWait: if (i_rdValid) nxtState = Idle;   // latch is loaded by then
			Line: if (i_pxReady && spanLast) nxtState = Idle;
			Palette: if (i_palDone) nxtState = Idle;
			default: nxtState = Idle;
		endcase
	end

	////////////////////
	// outputs
	////////////////////
	assign o_cmdReady   = (state == Idle);
	assign o_engineBusy = (state != Idle);
	assign o_pxValid    = (state == Pixel) || (state == Read) || (state == Line);
	assign o_palValid   = (state == Palette);

	always_comb begin
		o_px.x      = cmdRegs.x1;
		o_px.y      = cmdRegs.y1;
		o_px.colour = cmdRegs.colour[gfxPkg::PixelW-1:0];
		o_px.write  = (state != Read);
		if (state == Line) begin
			if (isVert)
				o_px.y = spanPos;   // column fixed at x1
			else
				o_px.x = spanPos;   // row fixed at y1
		end
	end

	// entry from colour, rgb is x1 low byte then y1
	assign o_pal.addr = cmdRegs.colour[gfxPkg::PaletteAddrW-1:0];
	assign o_pal.rgb  = {cmdRegs.x1[7:0], cmdRegs.y1};

endmodule

/* logic/frameBufferPort.sv */
`timescale 1ns/100ps
module frameBufferPort #(
	parameter int SramReadLat = gfxPkg::SramReadLatDef
) (
	input  logic                         Clk,
	input  logic                         i_rstN,
	input  logic                         i_pxValid,
	input  gfxPkg::pixelReq_t            i_px,
	input  logic [15:0]                  i_sramRdata,
	output logic                         o_pxReady,
	output gfxPkg::sramBus_t             o_sram,
	output logic                         o_rdValid,
	output logic [gfxPkg::PixelW-1:0]    o_rdByte
);

	logic                      accept;
	logic                      rdAccept;
	logic [SramReadLat-1:0]    rdPipe;    // read marker, one stage per cycle
	logic [SramReadLat-1:0]    oddPipe;   // x parity travelling with it
	gfxPkg::sramBus_t          nxtSram;

	assign o_pxReady = ~|rdPipe;   // hold off while a read is in flight
	assign accept    = i_pxValid && o_pxReady;
	assign rdAccept  = accept && !i_px.write;

	////////////////////
	// request mapping
	////////////////////
	always_comb begin
		nxtSram.addr  = {i_px.y[gfxPkg::YAddrBits-1:0], i_px.x[gfxPkg::XAddrBits-1:1]};
		nxtSram.wdata = {i_px.colour, i_px.colour};   // same byte on both halves
		nxtSram.udsN  = 1'b1;
		nxtSram.ldsN  = 1'b1;
		nxtSram.rwN   = 1'b1;
		if (accept) begin
			if (i_px.write) begin
				nxtSram.udsN = i_px.x[0];    // even pixel in upper half
				nxtSram.ldsN = !i_px.x[0];
				nxtSram.rwN  = 1'b0;
			end else begin
				nxtSram.udsN = 1'b0;         // fetch whole word
				nxtSram.ldsN = 1'b0;
			end
		end
	end

	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_sram    <= '{addr: '0, wdata: '0, udsN: 1'b1, ldsN: 1'b1, rwN: 1'b1};
			rdPipe    <= '0;
			o_rdValid <= 1'b0;
		end else begin
			o_sram    <= nxtSram;
			rdPipe[0] <= rdAccept;
			for (int i = 1; i < SramReadLat; i++)
				rdPipe[i] <= rdPipe[i-1];
			o_rdValid <= rdPipe[SramReadLat-1];
		end
	end

	////////////////////
	// read return
	////////////////////
	always_ff @(posedge Clk) begin
		oddPipe[0] <= i_px.x[0];
		for (int i = 1; i < SramReadLat; i++)
			oddPipe[i] <= oddPipe[i-1];
		if (rdPipe[SramReadLat-1])
			o_rdByte <= oddPipe[SramReadLat-1] ? i_sramRdata[7:0] : i_sramRdata[15:8];
	end

endmodule

/* logic/gfxPkg.sv */
package gfxPkg;

	////////////////////
	// widths
	////////////////////
	localparam int CoordW       = 16;                          // cpu register and coordinate width
	localparam int XAddrBits    = 10;                          // 1024 columns
	localparam int YAddrBits    = 9;                           // 512 rows
	localparam int SramAddrW    = YAddrBits + XAddrBits - 1;   // two pixels per sram word
	localparam int PixelW       = 8;                           // palette index
	localparam int PaletteAddrW = 6;                           // 64 palette entries
	localparam int RgbW         = 24;                          // 00RRGGBB without the top byte

	localparam int SramReadLatDef = 2;   // accept to capture of read data

	// byte offsets of the registers, upper address byte must be zero
	typedef enum logic [7:0] {
		OfsCmd    = 8'h00,   // command on write, status on read
		OfsX1     = 8'h02,
		OfsY1     = 8'h04,
		OfsX2     = 8'h06,
		OfsY2     = 8'h08,
		OfsColour = 8'h0E    // colour on write, colour latch on read
	} regOfs_e;

	typedef enum logic [CoordW-1:0] {
		HLine          = 16'h0001,
		VLine          = 16'h0002,
		PutPixel       = 16'h000A,
		GetPixel       = 16'h000B,
		ProgramPalette = 16'h0010
	} cmd_e;

	////////////////////
	// bundles
	////////////////////
	typedef struct packed {
		logic              csN;
		logic              asN;     // address strobe, cycle ends when high
		logic              udsN;    // upper byte lane
		logic              ldsN;    // lower byte lane
		logic              rw;      // 1 read, 0 write
		logic [CoordW-1:0] addr;
		logic [CoordW-1:0] wdata;
	} cpuBus_t;

	typedef struct packed {
		logic [CoordW-1:0] x1;
		logic [CoordW-1:0] y1;
		logic [CoordW-1:0] x2;
		logic [CoordW-1:0] y2;
		logic [CoordW-1:0] colour;
		logic [CoordW-1:0] command;
	} drawRegs_t;

	typedef struct packed {
		logic [CoordW-1:0] x;
		logic [CoordW-1:0] y;
		logic [PixelW-1:0] colour;
		logic              write;   // 0 means pixel read
	} pixelReq_t;

	typedef struct packed {
		logic [SramAddrW-1:0] addr;
		logic [15:0]          wdata;
		logic                 udsN;
		logic                 ldsN;
		logic                 rwN;
	} sramBus_t;

	typedef struct packed {
		logic [PaletteAddrW-1:0] addr;
		logic [RgbW-1:0]         rgb;
	} paletteWr_t;

endpackage

/* logic/gfxRegs.sv */
`timescale 1ns/100ps
module gfxRegs (
	input  logic                         Clk,
	input  logic                         i_rstN,
	input  gfxPkg::cpuBus_t              i_cpuBus,
	input  logic                         i_cmdReady,
	input  logic                         i_engineBusy,
	input  logic                         i_rdValid,
	input  logic [gfxPkg::PixelW-1:0]    i_rdByte,
	output gfxPkg::drawRegs_t            o_regs,
	output logic                         o_cmdValid,
	output logic [gfxPkg::CoordW-1:0]    o_cpuRdata
);

	logic                         decodeOk;      // chip selected, strobe low, our page
	logic                         wrEn;
	logic                         rdEn;
	logic [7:0]                   ofs;           // word aligned offset
	logic                         cmdWr;
	logic                         cmdPending;
	logic                         engineIdle;
	logic [gfxPkg::CoordW-1:0]    colourLatch;   // last pixel read back

	// only the lanes with a low strobe take new data
	function automatic logic [gfxPkg::CoordW-1:0] laneWr(
		input logic [gfxPkg::CoordW-1:0] old,
		input gfxPkg::cpuBus_t           bus
	);
		laneWr = old;
		if (!bus.udsN)
			laneWr[15:8] = bus.wdata[15:8];
		if (!bus.ldsN)
			laneWr[7:0] = bus.wdata[7:0];
	endfunction

	////////////////////
	// address decode
	////////////////////
	assign decodeOk = !i_cpuBus.csN && !i_cpuBus.asN && (i_cpuBus.addr[15:8] == 8'h00);
	assign wrEn     = decodeOk && !i_cpuBus.rw;
	assign rdEn     = decodeOk && i_cpuBus.rw;
	assign ofs      = {i_cpuBus.addr[7:1], 1'b0};   // byte address within the word ignored
	assign cmdWr    = wrEn && (ofs == gfxPkg::OfsCmd);

	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_regs <= '{x1: '0, y1: '0, x2: 16'h0400, y2: 16'h0200,
				colour: 16'h0004, command: '0};   // full screen corners, palette entry 4
		end else if (wrEn) begin
			case (ofs)
				gfxPkg::OfsCmd:    o_regs.command <= laneWr(o_regs.command, i_cpuBus);
				gfxPkg::OfsX1:     o_regs.x1      <= laneWr(o_regs.x1, i_cpuBus);
				gfxPkg::OfsY1:     o_regs.y1      <= laneWr(o_regs.y1, i_cpuBus);
				gfxPkg::OfsX2:     o_regs.x2      <= laneWr(o_regs.x2, i_cpuBus);
				gfxPkg::OfsY2:     o_regs.y2      <= laneWr(o_regs.y2, i_cpuBus);
				gfxPkg::OfsColour: o_regs.colour  <= laneWr(o_regs.colour, i_cpuBus);
				default: ;                                            // unmapped offset
			endcase
		end
	end

	////////////////////
	// command hand-off
	////////////////////
	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN) begin
			cmdPending <= 1'b0;
		end else if (cmdWr) begin
			cmdPending <= 1'b1;
		end else if (o_cmdValid && i_cmdReady) begin
			cmdPending <= 1'b0;   // sequencer has taken the registers
		end
	end

	// offer the command only once the cpu cycle has ended
	assign o_cmdValid = cmdPending && i_cpuBus.asN;

	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN)
			colourLatch <= '0;
		else if (i_rdValid)
			colourLatch <= {{(gfxPkg::CoordW - gfxPkg::PixelW){1'b0}}, i_rdByte};
	end

	////////////////////
	// readback
	////////////////////
	assign engineIdle = !cmdPending && !i_engineBusy;   // status bit 0

	always_comb begin
		o_cpuRdata = '0;   // nothing selected reads as zero
		if (rdEn) begin
			if (ofs == gfxPkg::OfsCmd)
				o_cpuRdata = {{(gfxPkg::CoordW - 1){1'b0}}, engineIdle};
			else if (ofs == gfxPkg::OfsColour)
				o_cpuRdata = colourLatch;
		end
	end

endmodule

/* logic/graphicsController.sv */
`timescale 1ns/100ps
module graphicsController #(
	parameter int SramReadLat = gfxPkg::SramReadLatDef   // sram read pipeline depth
) (
	input  logic                         Clk,
	input  logic                         i_rstN,
	input  gfxPkg::cpuBus_t              i_cpuBus,
	input  logic                         i_vSyncN,
	input  logic [15:0]                  i_sramRdata,
	output logic [gfxPkg::CoordW-1:0]    o_cpuRdata,
	output gfxPkg::sramBus_t             o_sram,
	output gfxPkg::paletteWr_t           o_palette,
	output logic                         o_paletteWe
);

	gfxPkg::drawRegs_t            regs;
	logic                         cmdValid;
	logic                         cmdReady;
	logic                         engineBusy;
	logic                         pxValid;     // pixel request path
	logic                         pxReady;
	gfxPkg::pixelReq_t            px;
	logic                         rdValid;     // read return
	logic [gfxPkg::PixelW-1:0]    rdByte;
	logic                         palValid;    // palette path
	gfxPkg::paletteWr_t           pal;
	logic                         palDone;

	gfxRegs gfxRegs_i (
		.Clk          (Clk),
		.i_rstN       (i_rstN),
		.i_cpuBus     (i_cpuBus),
		.i_cmdReady   (cmdReady),
		.i_engineBusy (engineBusy),
		.i_rdValid    (rdValid),
		.i_rdByte     (rdByte),
		.o_regs       (regs),
		.o_cmdValid   (cmdValid),
		.o_cpuRdata   (o_cpuRdata)
	);

	drawSequencer drawSequencer_i (
		.Clk          (Clk),
		.i_rstN       (i_rstN),
		.i_cmdValid   (cmdValid),
		.i_regs       (regs),
		.i_pxReady    (pxReady),
		.i_rdValid    (rdValid),
		.i_palDone    (palDone),
		.o_cmdReady   (cmdReady),
		.o_engineBusy (engineBusy),
		.o_pxValid    (pxValid),
		.o_px         (px),
		.o_palValid   (palValid),
		.o_pal        (pal)
	);

	frameBufferPort #(
		.SramReadLat (SramReadLat)
	) frameBufferPort_i (
		.Clk         (Clk),
		.i_rstN      (i_rstN),
		.i_pxValid   (pxValid),
		.i_px        (px),
		.i_sramRdata (i_sramRdata),
		.o_pxReady   (pxReady),
		.o_sram      (o_sram),
		.o_rdValid   (rdValid),
		.o_rdByte    (rdByte)
	);

	paletteLoader paletteLoader_i (
		.Clk         (Clk),
		.i_rstN      (i_rstN),
		.i_palValid  (palValid),
		.i_pal       (pal),
		.i_vSyncN    (i_vSyncN),
		.o_palDone   (palDone),
		.o_palette   (o_palette),
		.o_paletteWe (o_paletteWe)
	);

endmodule

/* logic/paletteLoader.sv */
`timescale 1ns/100ps
module paletteLoader (
	input  logic                  Clk,
	input  logic                  i_rstN,
	input  logic                  i_palValid,
	input  gfxPkg::paletteWr_t    i_pal,
	input  logic                  i_vSyncN,
	output logic                  o_palDone,
	output gfxPkg::paletteWr_t    o_palette,
	output logic                  o_paletteWe
);

	logic held;   // request waiting for blanking
	logic take;

	// no retake in the pulse cycle while the sequencer still shows valid
	assign take = i_palValid && !held && !o_paletteWe;

	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN) begin
			held        <= 1'b0;
			o_paletteWe <= 1'b0;
		end else begin
			o_paletteWe <= held && !i_vSyncN;   // write only in vertical blanking
			if (held && !i_vSyncN)
				held <= 1'b0;
			else if (take)
				held <= 1'b1;
		end
	end

	always_ff @(posedge Clk) begin
		if (take)
			o_palette <= i_pal;   // stays put through active video
	end

	assign o_palDone = o_paletteWe;

endmodule

/* logic/spanWalker.sv */
`timescale 1ns/100ps
module spanWalker (
	input  logic                         Clk,
	input  logic                         i_rstN,
	input  logic                         i_load,
	input  logic [gfxPkg::CoordW-1:0]    i_start,
	input  logic [gfxPkg::CoordW-1:0]    i_end,
	input  logic                         i_step,
	output logic [gfxPkg::CoordW-1:0]    o_pos,
	output logic                         o_last
);

	logic [gfxPkg::CoordW-1:0] endPos;   // latched end of the span

	always_ff @(posedge Clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_pos  <= '0;
			endPos <= '0;
		end else if (i_load) begin
			o_pos  <= i_start;
			endPos <= i_end;
		end else if (i_step) begin
			o_pos <= o_pos + 1'b1;   // one pixel per accepted request
		end
	end

	// signed so a negative end still stops at the start
	assign o_last = ($signed(o_pos) >= $signed(endPos));

endmodule

/* sim/frameBufferModel.sv */
`timescale 1ns/100ps
module frameBufferModel #(
	parameter int ReadLat = gfxPkg::SramReadLatDef   // at least 2
) (
	input  logic                Clk,
	input  gfxPkg::sramBus_t    i_sram,
	output logic [15:0]         o_rdata
);

	logic [15:0] mem [0:(1 << gfxPkg::SramAddrW) - 1];   // two pixels per word
	logic [15:0] rdPipe [0:ReadLat-2];                   // read data delay line

	// preload so untouched pixels are not all alike
	initial begin : preload
		logic [gfxPkg::SramAddrW-1:0] a;
		for (int i = 0; i < (1 << gfxPkg::SramAddrW); i++) begin
			a      = i;
			mem[i] = a[15:0] ^ {8{a[17:16]}};   // every address bit counts
		end
		for (int i = 0; i < ReadLat - 1; i++)
			rdPipe[i] = '0;
	end

	always @(posedge Clk) begin
		if (!i_sram.rwN) begin
			if (!i_sram.udsN)
				mem[i_sram.addr][15:8] <= i_sram.wdata[15:8];
			if (!i_sram.ldsN)
				mem[i_sram.addr][7:0] <= i_sram.wdata[7:0];
		end
		rdPipe[0] <= mem[i_sram.addr];   // sync read returns old data on a write cycle
		for (int i = 1; i < ReadLat - 1; i++)
			rdPipe[i] <= rdPipe[i-1];
	end

	assign o_rdata = rdPipe[ReadLat-2];

endmodule

/* sim/graphicsController_asserts.sv */
`timescale 1ns/100ps
module graphicsController_asserts (
	input  logic                Clk,
	input  logic                i_rstN,
	input  gfxPkg::sramBus_t    i_sram,
	input  logic                i_paletteWe,
	input  logic                i_vSyncN
);

	int failCount = 0;   // read by the testbench at the end

	////////////////////
	// sram protocol
	////////////////////
	writeOneLane: assert property (@(posedge Clk) disable iff (!i_rstN)
		!i_sram.rwN |-> (i_sram.udsN || i_sram.ldsN))
		else begin
			failCount++;
			$error("sram write drives both byte lanes");
		end

	////////////////////
	// palette protocol
	////////////////////
	paletteSinglePulse: assert property (@(posedge Clk) disable iff (!i_rstN)
		i_paletteWe |=> !i_paletteWe)
		else begin
			failCount++;
			$error("palette write enable high for two cycles");
		end

	paletteInBlanking: assert property (@(posedge Clk) disable iff (!i_rstN)
		$rose(i_paletteWe) |-> $past(!i_vSyncN))   // only after vsync seen low
		else begin
			failCount++;
			$error("palette write outside vertical blanking");
		end

endmodule

bind graphicsController graphicsController_asserts graphicsController_asserts_i (
	.Clk         (Clk),
	.i_rstN      (i_rstN),
	.i_sram      (o_sram),
	.i_paletteWe (o_paletteWe),
	.i_vSyncN    (i_vSyncN)
);

/* sim/graphicsController_tb.sv */
`timescale 1ns/100ps
module graphicsController_tb;

	localparam int SramReadLat  = gfxPkg::SramReadLatDef;
	localparam int IdleTimeout  = 200;    // status polls
	localparam int DrainTimeout = 1000;   // cycles
	localparam int PalWindow    = 40;     // cycles with vsync high
	localparam int PalTimeout   = 50;
	localparam gfxPkg::cpuBus_t BusIdle = '{csN: 1'b1, asN: 1'b1, udsN: 1'b1, ldsN: 1'b1,
		rw: 1'b1, addr: '0, wdata: '0};

	logic                         Clk;
	logic                         rstN;
	gfxPkg::cpuBus_t              cpuBus;
	logic                         vSyncN;
	logic [15:0]                  sramRdata;
	logic [gfxPkg::CoordW-1:0]    cpuRdata;
	gfxPkg::sramBus_t             sram;
	gfxPkg::paletteWr_t           palette;
	logic                         paletteWe;

	logic [31:0]           lfsr;
	logic [7:0]            shadow [0:(1 << 19) - 1];      // expected pixel indexed by {y, x}
	bit                    shadowSet [0:(1 << 19) - 1];   // pixel drawn by a command
	logic [31:0]           checkQ [$];                    // {x, y} waiting for compare
	gfxPkg::paletteWr_t    expPal;
	int                    palPulses = 0;

	graphicsController #(
		.SramReadLat (SramReadLat)
	) graphicsController_i (
		.Clk         (Clk),
		.i_rstN      (rstN),
		.i_cpuBus    (cpuBus),
		.i_vSyncN    (vSyncN),
		.i_sramRdata (sramRdata),
		.o_cpuRdata  (cpuRdata),
		.o_sram      (sram),
		.o_palette   (palette),
		.o_paletteWe (paletteWe)
	);

	frameBufferModel #(
		.ReadLat (SramReadLat)
	) frameBufferModel_i (
		.Clk     (Clk),
		.i_sram  (sram),
		.o_rdata (sramRdata)
	);

	always #5 Clk = ~Clk;   // 10 ns period

	////////////////////
	// reference
	////////////////////
	// taps 32 22 2 1 with the new bit entering at the bottom
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] fillWord(input logic [gfxPkg::SramAddrW-1:0] a);
		fillWord = a[15:0] ^ {8{a[17:16]}};   // model preload
	endfunction

	function automatic logic [7:0] expectedByte(input logic [15:0] x, input logic [15:0] y);
		logic [18:0] idx;
		logic [15:0] word;
		idx  = {y[8:0], x[9:0]};
		word = fillWord({y[8:0], x[9:1]});
		if (shadowSet[idx])
			expectedByte = shadow[idx];
		else
			expectedByte = x[0] ? word[7:0] : word[15:8];   // even pixel in upper half
	endfunction

	function automatic logic [7:0] modelByte(input logic [15:0] x, input logic [15:0] y);
		logic [15:0] word;
		word      = frameBufferModel_i.mem[{y[8:0], x[9:1]}];
		modelByte = x[0] ? word[7:0] : word[15:8];
	endfunction

	////////////////////
	// checks
	////////////////////
	task automatic stopRun();
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkByte(input string what, input logic [gfxPkg::PixelW-1:0] got,
		input logic [gfxPkg::PixelW-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %h expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic checkWord(input string what, input logic [gfxPkg::CoordW-1:0] got,
		input logic [gfxPkg::CoordW-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %h expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic checkPalette(input string what, input gfxPkg::paletteWr_t got,
		input gfxPkg::paletteWr_t exp);
		if (got !== exp) begin
			$display("MISMATCH %0t %s got %h expected %h", $time, what, got, exp);
			stopRun();
		end
	endtask

	// compares one pixel per cycle plus every palette pulse
	always @(negedge Clk) begin : compareResults
		logic [31:0] item;
		if (graphicsController_i.graphicsController_asserts_i.failCount != 0) begin
			$display("a protocol assertion on the SRAM or palette outputs failed");
			stopRun();
		end
		if (checkQ.size() != 0) begin
			item = checkQ.pop_front();
			checkByte($sformatf("pixel (%0d,%0d)", item[31:16], item[15:0]),
				modelByte(item[31:16], item[15:0]), expectedByte(item[31:16], item[15:0]));
		end
		if (paletteWe) begin
			palPulses++;
			checkPalette("o_palette", palette, expPal);
		end
	end

	////////////////////
	// stimulus helpers
	////////////////////
	task automatic randomBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v    = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic cpuWrite(input gfxPkg::regOfs_e ofs, input logic [15:0] data,
		input logic udsN, input logic ldsN);
		@(posedge Clk);
		cpuBus <= '{csN: 1'b0, asN: 1'b0, udsN: udsN, ldsN: ldsN, rw: 1'b0,
			addr: {8'h00, ofs}, wdata: data};
		@(posedge Clk);
		@(posedge Clk);
		cpuBus <= BusIdle;   // end of the two cycle access
	endtask

	task automatic writeWord(input gfxPkg::regOfs_e ofs, input logic [15:0] data);
		cpuWrite(ofs, data, 1'b0, 1'b0);
	endtask

	task automatic cpuRead(input gfxPkg::regOfs_e ofs, output logic [15:0] data);
		@(posedge Clk);
		cpuBus <= '{csN: 1'b0, asN: 1'b0, udsN: 1'b0, ldsN: 1'b0, rw: 1'b1,
			addr: {8'h00, ofs}, wdata: '0};
		@(posedge Clk);
		@(negedge Clk);
		data = cpuRdata;   // sampled mid cycle while the bus is stable
		@(posedge Clk);
		cpuBus <= BusIdle;
	endtask

	task automatic waitIdle(input string what);
		logic [15:0] st;
		int          polls;
		st    = '0;
		polls = 0;
		while (!st[0] && polls < IdleTimeout) begin
			cpuRead(gfxPkg::OfsCmd, st);
			polls++;
		end
		if (!st[0]) begin
			$display("timeout, status never returned to idle after %s", what);
			stopRun();
		end
	endtask

	task automatic drainChecks();
		int n;
		n = 0;
		while (checkQ.size() != 0 && n < DrainTimeout) begin
			@(posedge Clk);
			n++;
		end
		if (checkQ.size() != 0) begin
			$display("timeout, pixel compares did not finish");
			stopRun();
		end
	endtask

	task automatic markPixel(input logic [15:0] x, input logic [15:0] y, input logic [7:0] c);
		shadow[{y[8:0], x[9:0]}]    = c;
		shadowSet[{y[8:0], x[9:0]}] = 1'b1;
	endtask

	task automatic pushCheck(input logic [15:0] x, input logic [15:0] y);
		checkQ.push_back({x, y});
	endtask

	task automatic drawLine(input logic vert, input logic [15:0] spanStart,
		input logic [15:0] spanEnd, input logic [15:0] fixedPos, input logic [7:0] colour);
		logic [15:0] stop;
		logic [15:0] p;
		stop = (spanEnd < spanStart) ? spanStart : spanEnd;   // reversed span gives start only
		if (vert) begin
			writeWord(gfxPkg::OfsX1, fixedPos);
			writeWord(gfxPkg::OfsY1, spanStart);
			writeWord(gfxPkg::OfsY2, spanEnd);
		end else begin
			writeWord(gfxPkg::OfsX1, spanStart);
			writeWord(gfxPkg::OfsY1, fixedPos);
			writeWord(gfxPkg::OfsX2, spanEnd);
		end
		writeWord(gfxPkg::OfsColour, {8'h00, colour});
		if (vert)
			writeWord(gfxPkg::OfsCmd, gfxPkg::VLine);
		else
			writeWord(gfxPkg::OfsCmd, gfxPkg::HLine);
		waitIdle(vert ? "vertical line" : "horizontal line");
		for (p = spanStart; p <= stop; p++)
			markPixel(vert ? fixedPos : p, vert ? p : fixedPos, colour);
		for (p = spanStart - 1; p <= stop + 1; p++)   // one pixel beyond each end
			pushCheck(vert ? fixedPos : p, vert ? p : fixedPos);
		drainChecks();
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin : stimulus
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] c;
		logic [15:0] len;
		logic [15:0] rd;
		int          n;
		bit          seen;
		Clk    = 1'b0;
		rstN   = 1'b0;
		vSyncN = 1'b1;   // active video
		cpuBus = BusIdle;
		lfsr   = 32'hbc902e19;
		repeat (4) @(posedge Clk);
		rstN <= 1'b1;

		// state after reset
		@(negedge Clk);
		checkWord("o_paletteWe", {15'b0, paletteWe}, 16'h0000);
		checkWord("o_sram strobes", {13'b0, sram.udsN, sram.ldsN, sram.rwN}, 16'h0007);
		cpuRead(gfxPkg::OfsCmd, rd);
		checkWord("status", rd, 16'h0001);
		cpuRead(gfxPkg::OfsColour, rd);
		checkWord("colour latch", rd, 16'h0000);

		// put pixel then get it back in even and odd columns
		for (int i = 0; i < 6; i++) begin
			randomBits(10, x);
			x[0] = i[0];
			randomBits(9, y);
			randomBits(8, c);
			writeWord(gfxPkg::OfsX1, x);
			writeWord(gfxPkg::OfsY1, y);
			writeWord(gfxPkg::OfsColour, c);
			writeWord(gfxPkg::OfsCmd, gfxPkg::PutPixel);
			waitIdle("put pixel");
			markPixel(x, y, c[7:0]);
			pushCheck(x, y);
			pushCheck(x ^ 16'h0001, y);   // partner byte in the same word
			drainChecks();
			writeWord(gfxPkg::OfsCmd, gfxPkg::GetPixel);
			waitIdle("get pixel");
			cpuRead(gfxPkg::OfsColour, rd);
			checkWord("colour latch", rd, {8'h00, expectedByte(x, y)});
		end

		// a low lane write turns X1 into 0x0145
		randomBits(9, y);
		randomBits(8, c);
		writeWord(gfxPkg::OfsX1, 16'h0123);
		cpuWrite(gfxPkg::OfsX1, 16'hff45, 1'b1, 1'b0);
		writeWord(gfxPkg::OfsY1, y);
		writeWord(gfxPkg::OfsColour, c);
		writeWord(gfxPkg::OfsCmd, gfxPkg::PutPixel);
		waitIdle("put pixel after lane write");
		markPixel(16'h0145, y, c[7:0]);
		pushCheck(16'h0145, y);
		pushCheck(16'h0144, y);
		pushCheck(16'h0345, y);   // where a full word write would have landed
		drainChecks();

		// horizontal lines forward then reversed
		for (int i = 0; i < 3; i++) begin
			randomBits(9, x);
			randomBits(5, len);
			randomBits(9, y);
			randomBits(8, c);
			drawLine(1'b0, x + 16'd1, x + 16'd1 + len, y, c[7:0]);
		end
		randomBits(9, x);
		randomBits(9, y);
		randomBits(8, c);
		drawLine(1'b0, x + 16'd4, x + 16'd1, y, c[7:0]);

		// vertical lines
		for (int i = 0; i < 3; i++) begin
			randomBits(8, y);
			randomBits(5, len);
			randomBits(10, x);
			randomBits(8, c);
			drawLine(1'b1, y + 16'd1, y + 16'd1 + len, x, c[7:0]);
		end
		randomBits(8, y);
		randomBits(10, x);
		randomBits(8, c);
		drawLine(1'b1, y + 16'd4, y + 16'd1, x, c[7:0]);

		// palette load held off until vsync goes low
		randomBits(16, x);
		randomBits(16, y);
		randomBits(16, c);
		writeWord(gfxPkg::OfsX1, x);
		writeWord(gfxPkg::OfsY1, y);
		writeWord(gfxPkg::OfsColour, c);
		expPal.addr = c[5:0];
		expPal.rgb  = {x[7:0], y};
		writeWord(gfxPkg::OfsCmd, gfxPkg::ProgramPalette);
		for (int i = 0; i < PalWindow; i++)
			@(negedge Clk);
		cpuRead(gfxPkg::OfsCmd, rd);
		checkWord("status during active video", rd, 16'h0000);
		checkWord("palette pulses during active video", palPulses[15:0], 16'h0000);
		@(posedge Clk);
		vSyncN <= 1'b0;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < PalTimeout) begin
			@(negedge Clk);
			n++;
			seen = paletteWe;
		end
		if (!seen) begin
			$display("timeout, no palette write pulse in vertical blanking");
			stopRun();
		end
		checkWord("palette pulse delay", n[15:0], 16'h0002);   // sample edge then pulse
		repeat (8) @(posedge Clk);
		vSyncN <= 1'b1;
		waitIdle("program palette");

		if (palPulses == 1 &&
			graphicsController_i.graphicsController_asserts_i.failCount == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("palette pulse count wrong or a protocol assertion fired");
			stopRun();
		end
	end

endmodule
